/* design/core_pkg.sv */
/*
   Shared definitions for the 16-bit in-order pipeline.
   Holds the word and register index types, the opcode and ALU
   encodings, and the control struct that every stage passes on.
   Modules take what they need by a wildcard import in their body.
*/
package core_pkg;

   // Basic data types
   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_idx_t;

   // Major opcodes, instruction bits 15:11
   typedef enum logic [4:0] {
      OP_NOP   = 5'b00001,
      OP_ADDI  = 5'b01000,
      OP_ST    = 5'b10000,
      OP_LD    = 5'b10001,
      OP_STU   = 5'b10011,
      OP_RTYPE = 5'b11011
   } opcode_t;

   // ALU operations, same encoding as the R-format funct field
   typedef enum logic [1:0] {
      ALU_ADD  = 2'b00,
      ALU_SUB  = 2'b01,  // Rs minus Rt
      ALU_XOR  = 2'b10,
      ALU_ANDN = 2'b11   // Rs and not Rt
   } alu_op_t;

   // Control bundle built in decode
   typedef struct packed {
      alu_op_t  alu_op;
      logic     use_imm;
      logic     mem_en;
      logic     mem_wrt;
      logic     mem_to_reg;
      logic     reg_wrt;
      reg_idx_t dest;
      reg_idx_t src_a;
      reg_idx_t src_b;   // ALU operand B or store data register
      word_t    imm;     // Sign-extended 5-bit immediate
   } ctrl_t;

endpackage

/* design/pipe_if.sv */
/*
   One link between two pipeline stages.
   The upstream stage drives it through the source modport and the
   downstream stage reads it through the sink modport.
*/
interface pipe_if;
   import core_pkg::*;

   logic  valid;
   ctrl_t ctrl;
   // Operands, or base and store data for memory ops
   word_t a_val;
   word_t b_val;
   // ALU result or memory address
   word_t result;
   word_t load_data;

   modport source (
      output valid, ctrl, a_val, b_val, result, load_data
   );

   modport sink (
      input valid, ctrl, a_val, b_val, result, load_data
   );

endinterface

/* design/reg_file.sv */
/*
   Register file with eight 16-bit registers.
   Two combinational read ports, one write port from the result stage.
   A read of the register written this cycle returns the new data.
*/
module reg_file (
   input  logic               clk,
   input  logic               reset,
   input  core_pkg::reg_idx_t rd_idx_a,
   input  core_pkg::reg_idx_t rd_idx_b,
   output core_pkg::word_t    rd_val_a,
   output core_pkg::word_t    rd_val_b,
   input  logic               wb_en,
   input  core_pkg::reg_idx_t wb_rd,
   input  core_pkg::word_t    wb_data
);
   import core_pkg::*;

   word_t regs [8];

   //////////////////////////////////////////////////////////////////////
   // Write port
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_en) begin
         regs[wb_rd] <= wb_data;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Read ports
   //////////////////////////////////////////////////////////////////////

   // Bypass for the write landing at the coming edge
   assign rd_val_a = (wb_en && wb_rd == rd_idx_a) ? wb_data : regs[rd_idx_a];
   assign rd_val_b = (wb_en && wb_rd == rd_idx_b) ? wb_data : regs[rd_idx_b];

endmodule

/* design/decode_stage.sv */
/*
   Decode stage.
   Splits the incoming instruction into fields, builds the control
   bundle, reads both source registers and registers it all into the
   decode-to-execute link. Unknown opcodes go on as bubbles.
*/
module decode_stage (
   input  logic               clk,
   input  logic               reset,
   input  logic               instr_valid,
   input  core_pkg::word_t    instr,
   output core_pkg::reg_idx_t rd_idx_a,
   output core_pkg::reg_idx_t rd_idx_b,
   input  core_pkg::word_t    rd_val_a,
   input  core_pkg::word_t    rd_val_b,
   pipe_if.source             dx
);
   import core_pkg::*;

   logic [4:0] opcode;
   ctrl_t      dec_ctrl;

   assign opcode = instr[15:11];

   //////////////////////////////////////////////////////////////////////
   // Control generation
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      dec_ctrl        = '0;
      dec_ctrl.alu_op = ALU_ADD;
      dec_ctrl.src_a  = instr[10:8];
      dec_ctrl.src_b  = instr[7:5];
      dec_ctrl.imm    = {{11{instr[4]}}, instr[4:0]};
      // 100xx group, writes when low bits match
      dec_ctrl.mem_wrt = (opcode[4:2] == 3'b100) && ~^opcode[1:0];
      // Enabled unless low bits are 10
      dec_ctrl.mem_en  = (opcode[4:2] == 3'b100) && (opcode[1:0] != 2'b10);
      case (opcode)
         OP_ADDI: begin
            dec_ctrl.use_imm = 1'b1;
            dec_ctrl.reg_wrt = 1'b1;
            dec_ctrl.dest    = instr[7:5];
         end
         OP_RTYPE: begin
            dec_ctrl.alu_op  = alu_op_t'(instr[1:0]);
            dec_ctrl.reg_wrt = 1'b1;
            dec_ctrl.dest    = instr[4:2];
         end
         OP_ST: begin
            dec_ctrl.use_imm = 1'b1;
         end
         OP_LD: begin
            dec_ctrl.use_imm    = 1'b1;
            dec_ctrl.reg_wrt    = 1'b1;
            dec_ctrl.mem_to_reg = 1'b1;
            dec_ctrl.dest       = instr[7:5];
         end
         OP_STU: begin
            // Updated base goes back into Rs
            dec_ctrl.use_imm = 1'b1;
            dec_ctrl.reg_wrt = 1'b1;
            dec_ctrl.dest    = instr[10:8];
         end
         OP_NOP: begin
            // Plain bubble
         end
         default: begin
            dec_ctrl.mem_en  = 1'b0;
            dec_ctrl.mem_wrt = 1'b0;
         end
      endcase
   end

   // Register file read indices
   assign rd_idx_a = dec_ctrl.src_a;
   assign rd_idx_b = dec_ctrl.src_b;

   //////////////////////////////////////////////////////////////////////
   // Decode-to-execute register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         dx.valid <= 1'b0;
         dx.ctrl  <= '0;
      end else begin
         dx.valid <= instr_valid;
         dx.ctrl  <= dec_ctrl;
      end
      dx.a_val <= rd_val_a;
      dx.b_val <= rd_val_b;
   end

   // Nothing computed yet at this point
   assign dx.result    = '0;
   assign dx.load_data = '0;

   a_instr_known: assert property (@(posedge clk) disable iff (reset)
      instr_valid |-> !$isunknown(instr))
      else $error("instruction has unknown bits while instr_valid is high");

endmodule

/* design/execute_stage.sv */
/*
   Execute stage.
   Forwards operands from the memory stage and from write-back, runs the
   ALU or the address add, and registers the result, the store data and
   the control into the execute-to-memory link.
*/
module execute_stage (
   input  logic               clk,
   input  logic               reset,
   pipe_if.sink               dx,
   pipe_if.source             xm,
   input  logic               wb_en,
   input  core_pkg::reg_idx_t wb_rd,
   input  core_pkg::word_t    wb_data
);
   import core_pkg::*;

   word_t a_fwd;
   word_t b_fwd;
   word_t b_opnd;
   word_t alu_out;

   //////////////////////////////////////////////////////////////////////
   // Operand forwarding
   //////////////////////////////////////////////////////////////////////

   // Newest producer wins, loads in xm are never forwarded
   function automatic word_t fwd(input reg_idx_t src, input word_t rf_val);
      if (xm.valid && xm.ctrl.reg_wrt && !xm.ctrl.mem_to_reg && xm.ctrl.dest == src) begin
         return xm.result;
      end else if (wb_en && wb_rd == src) begin
         return wb_data;
      end else begin
         return rf_val;
      end
   endfunction

   assign a_fwd = fwd(dx.ctrl.src_a, dx.a_val);
   // Also the store data for memory ops
   assign b_fwd = fwd(dx.ctrl.src_b, dx.b_val);

   //////////////////////////////////////////////////////////////////////
   // ALU
   //////////////////////////////////////////////////////////////////////

   assign b_opnd = dx.ctrl.use_imm ? dx.ctrl.imm : b_fwd;

   always_comb begin
      case (dx.ctrl.alu_op)
         ALU_ADD:  alu_out = a_fwd + b_opnd;
         ALU_SUB:  alu_out = a_fwd - b_opnd;
         ALU_XOR:  alu_out = a_fwd ^ b_opnd;
         ALU_ANDN: alu_out = a_fwd & ~b_opnd;
         default:  alu_out = '0;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Execute-to-memory register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         xm.valid <= 1'b0;
         xm.ctrl  <= '0;
      end else begin
         xm.valid <= dx.valid;
         xm.ctrl  <= dx.ctrl;
      end
      xm.a_val  <= a_fwd;
      xm.b_val  <= b_fwd;
      xm.result <= alu_out;
   end

   // Filled in by the memory stage
   assign xm.load_data = '0;

   // Store address must come from base plus immediate
   a_store_imm: assert property (@(posedge clk) disable iff (reset)
      dx.valid && dx.ctrl.mem_wrt |-> dx.ctrl.use_imm)
      else $error("store reached execute without the immediate operand");

endmodule

/* design/memory_stage.sv */
/*
   Memory stage.
   Word-addressed data memory read combinationally at the execute
   result and written at the clock edge. Store data is refreshed from
   write-back when the instruction just ahead produced it. Drives the
   external store strobe and feeds the result stage.
*/
module memory_stage #(
   parameter int mem_words = 256
) (
   input  logic               clk,
   input  logic               reset,
   pipe_if.sink               xm,
   pipe_if.source             mr,
   input  logic               wb_en,
   input  core_pkg::reg_idx_t wb_rd,
   input  core_pkg::word_t    wb_data,
   output logic               mem_wr_en,
   output core_pkg::word_t    mem_wr_addr,
   output core_pkg::word_t    mem_wr_data
);
   import core_pkg::*;

   localparam int addr_bits = $clog2(mem_words);

   word_t                mem [mem_words];
   logic [addr_bits-1:0] addr;
   word_t                st_data;
   word_t                rd_data;

   // Upper address bits are ignored
   assign addr = xm.result[addr_bits-1:0];

   // Covers a load followed directly by a store of its result
   assign st_data = (wb_en && wb_rd == xm.ctrl.src_b) ? wb_data : xm.b_val;

   //////////////////////////////////////////////////////////////////////
   // Data memory
   //////////////////////////////////////////////////////////////////////

   assign mem_wr_en   = xm.valid & xm.ctrl.mem_wrt;
   assign mem_wr_addr = xm.result;
   assign mem_wr_data = st_data;

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < mem_words; i++) begin
            mem[i] <= '0;
         end
      end else if (mem_wr_en) begin
         mem[addr] <= st_data;
      end
   end

   // Old contents on a same-cycle write
   assign rd_data = (xm.valid && xm.ctrl.mem_en) ? mem[addr] : '0;

   //////////////////////////////////////////////////////////////////////
   // Link to the result stage
   //////////////////////////////////////////////////////////////////////

   assign mr.valid     = xm.valid;
   assign mr.ctrl      = xm.ctrl;
   assign mr.a_val     = xm.a_val;
   assign mr.b_val     = st_data;
   assign mr.result    = xm.result;
   assign mr.load_data = rd_data;

   a_wrt_has_en: assert property (@(posedge clk) disable iff (reset)
      xm.valid && xm.ctrl.mem_wrt |-> xm.ctrl.mem_en)
      else $error("memory write requested without memory enable");

endmodule

/* design/result_stage.sv */
/*
   Result stage.
   Registers the memory stage output and drives the register-file
   write port, with load data for loads and the ALU result otherwise.
*/
module result_stage (
   input  logic               clk,
   input  logic               reset,
   pipe_if.sink               mr,
   output logic               wb_en,
   output core_pkg::reg_idx_t wb_rd,
   output core_pkg::word_t    wb_data
);
   import core_pkg::*;

   logic  valid_q;
   ctrl_t ctrl_q;
   word_t result_q;
   word_t load_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= 1'b0;
         ctrl_q  <= '0;
      end else begin
         valid_q <= mr.valid;
         ctrl_q  <= mr.ctrl;
      end
      result_q <= mr.result;
      load_q   <= mr.load_data;
   end

   // Write-back select
   assign wb_en   = valid_q & ctrl_q.reg_wrt;
   assign wb_rd   = ctrl_q.dest;
   assign wb_data = ctrl_q.mem_to_reg ? load_q : result_q;

   a_wb_rd_known: assert property (@(posedge clk) disable iff (reset)
      wb_en |-> !$isunknown(wb_rd))
      else $error("write-back register index unknown while wb_en is high");

endmodule

/* design/pipe_core.sv */
/*
   Top level of the pipeline.
   Takes one instruction per clock with a valid strobe and exposes the
   register-file write port and the data memory store strobe. Write-back
   follows issue by three clocks, the store by two.
*/
module pipe_core #(
   parameter int mem_words = 256
) (
   input  logic               clk,
   input  logic               reset,
   input  logic               instr_valid,
   input  core_pkg::word_t    instr,
   output logic               wb_en,
   output core_pkg::reg_idx_t wb_rd,
   output core_pkg::word_t    wb_data,
   output logic               mem_wr_en,
   output core_pkg::word_t    mem_wr_addr,
   output core_pkg::word_t    mem_wr_data
);
   import core_pkg::*;

   // Register file read port
   reg_idx_t rd_idx_a;
   reg_idx_t rd_idx_b;
   word_t    rd_val_a;
   word_t    rd_val_b;

   // Stage links
   pipe_if dx ();
   pipe_if xm ();
   pipe_if mr ();

   reg_file u_reg_file (
      .clk      (clk),
      .reset    (reset),
      .rd_idx_a (rd_idx_a),
      .rd_idx_b (rd_idx_b),
      .rd_val_a (rd_val_a),
      .rd_val_b (rd_val_b),
      .wb_en    (wb_en),
      .wb_rd    (wb_rd),
      .wb_data  (wb_data)
   );

   decode_stage u_decode (
      .clk         (clk),
      .reset       (reset),
      .instr_valid (instr_valid),
      .instr       (instr),
      .rd_idx_a    (rd_idx_a),
      .rd_idx_b    (rd_idx_b),
      .rd_val_a    (rd_val_a),
      .rd_val_b    (rd_val_b),
      .dx          (dx)
   );

   execute_stage u_execute (
      .clk     (clk),
      .reset   (reset),
      .dx      (dx),
      .xm      (xm),
      .wb_en   (wb_en),
      .wb_rd   (wb_rd),
      .wb_data (wb_data)
   );

   memory_stage #(
      .mem_words (mem_words)
   ) u_memory (
      .clk         (clk),
      .reset       (reset),
      .xm          (xm),
      .mr          (mr),
      .wb_en       (wb_en),
      .wb_rd       (wb_rd),
      .wb_data     (wb_data),
      .mem_wr_en   (mem_wr_en),
      .mem_wr_addr (mem_wr_addr),
      .mem_wr_data (mem_wr_data)
   );

   result_stage u_result (
      .clk     (clk),
      .reset   (reset),
      .mr      (mr),
      .wb_en   (wb_en),
      .wb_rd   (wb_rd),
      .wb_data (wb_data)
   );

endmodule

/* sim/tb_pipe_core.sv */
/*
   Testbench for the pipeline top level.
   Issues a seeded random instruction stream, runs every instruction
   on an architectural model at issue time and checks the write-back
   and store strobes of the DUT cycle by cycle against the model.
*/
module tb_pipe_core;
   timeunit 1ns;
   timeprecision 100ps;
   import core_pkg::*;

   localparam int clk_period    = 8;
   localparam int reset_cycles  = 4;
   localparam int mem_words     = 256;
   localparam int n_instr       = 2000;
   localparam int n_reset_loads = 16;
   localparam int watchdog_ns   = (n_instr + 20) * clk_period + reset_cycles * clk_period;

   // Expected strobes, due is the edge where the write lands
   typedef struct packed {
      int       due;
      logic     ph;
      reg_idx_t rd;
      word_t    data;
   } wb_item_t;

   typedef struct packed {
      int    due;
      logic  ph;
      word_t addr;
      word_t data;
   } st_item_t;

   logic     clk;
   logic     reset;
   logic     instr_valid;
   word_t    instr;
   logic     wb_en;
   reg_idx_t wb_rd;
   word_t    wb_data;
   logic     mem_wr_en;
   word_t    mem_wr_addr;
   word_t    mem_wr_data;

   integer   seed;
   int       edge_cnt = 0;
   logic     checking = 1'b0;
   word_t    stim_instr [n_instr];
   logic     stim_valid [n_instr];
   word_t    model_regs [8];
   word_t    model_mem  [mem_words];
   wb_item_t wb_q [$];
   st_item_t st_q [$];

   pipe_core #(
      .mem_words (mem_words)
   ) dut0 (
      .clk         (clk),
      .reset       (reset),
      .instr_valid (instr_valid),
      .instr       (instr),
      .wb_en       (wb_en),
      .wb_rd       (wb_rd),
      .wb_data     (wb_data),
      .mem_wr_en   (mem_wr_en),
      .mem_wr_addr (mem_wr_addr),
      .mem_wr_data (mem_wr_data)
   );

   initial begin : clock_gen
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   // Rising edges seen so far
   always @(posedge clk) edge_cnt <= edge_cnt + 1;

   //////////////////////////////////////////////////////////////////////
   // Failure reporting and value checks
   //////////////////////////////////////////////////////////////////////

   task automatic stop_on_error();
      $display("Done: errors found");
      $fatal(1, "simulation stopped at the first error");
   endtask

   function automatic string test_name(input logic ph);
      return ph ? "random_stream" : "reset_loads";
   endfunction

   task automatic check_value(input string what, input logic ph, input word_t expected,
                              input word_t actual);
      if (actual !== expected) begin
         $display("Fail %s %s at edge %0d: expected %h, actual %h",
                  test_name(ph), what, edge_cnt + 1, expected, actual);
         stop_on_error();
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Stimulus generation
   //////////////////////////////////////////////////////////////////////

   function automatic logic is_defined(input logic [4:0] op);
      return op == OP_ADDI || op == OP_ST || op == OP_LD || op == OP_STU || op == OP_RTYPE;
   endfunction

   // ALU inputs only, store data is refreshed in the memory stage
   function automatic logic reads_alu_src(input word_t ins, input reg_idx_t r);
      case (ins[15:11])
         OP_ADDI, OP_ST, OP_LD, OP_STU: return ins[10:8] == r;
         OP_RTYPE: return ins[10:8] == r || ins[7:5] == r;
         default: return 1'b0;
      endcase
   endfunction

   task automatic build_stream();
      logic [31:0] rnd;
      logic [3:0]  kind;
      logic [10:0] fields;
      logic [4:0]  op;
      logic        valid;
      for (int i = 0; i < n_instr; i++) begin
         rnd    = $random(seed);
         kind   = rnd[3:0];
         fields = rnd[14:4];
         op     = rnd[19:15];
         valid  = 1'b1;
         if (i < n_reset_loads) op = OP_LD;
         else if (kind < 4'd4) op = OP_ADDI;
         else if (kind < 4'd8 || kind == 4'd15) op = OP_RTYPE;
         else if (kind < 4'd10) op = OP_ST;
         else if (kind < 4'd12) op = OP_LD;
         else if (kind == 4'd12) op = OP_STU;
         else if (kind == 4'd13) begin
            // Undefined opcode, or the plain bubble encoding
            if (is_defined(op)) op = OP_NOP;
         end else valid = 1'b0;
         // Now and then store the value that was just loaded
         if (i >= n_reset_loads && stim_valid[i-1] && stim_instr[i-1][15:11] == OP_LD &&
             rnd[21:20] == 2'b00) begin
            op          = OP_ST;
            valid       = 1'b1;
            fields[7:5] = stim_instr[i-1][7:5];
            if (fields[10:8] == fields[7:5]) fields[10:8] = fields[7:5] + 3'd1;
         end
         stim_instr[i] = {op, fields};
         stim_valid[i] = valid;
      end
      // No load result may feed the ALU of the very next instruction
      for (int i = 0; i < n_instr - 1; i++) begin
         if (stim_valid[i] && stim_instr[i][15:11] == OP_LD && stim_valid[i+1] &&
             reads_alu_src(stim_instr[i+1], stim_instr[i][7:5])) begin
            stim_instr[i][15:11] = OP_ADDI;
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Architectural model
   //////////////////////////////////////////////////////////////////////

   task automatic expect_write(input reg_idx_t rd, input word_t data, input int issue,
                               input logic ph);
      wb_item_t item;
      item.due = issue + 3;
      item.ph = ph;
      item.rd = rd;
      item.data = data;
      wb_q.push_back(item);
      model_regs[rd] = data;
   endtask

   task automatic expect_store(input word_t addr, input word_t data, input int issue,
                               input logic ph);
      st_item_t item;
      item.due = issue + 2;
      item.ph = ph;
      item.addr = addr;
      item.data = data;
      st_q.push_back(item);
      // Upper address bits wrap, as the memory decodes only the low ones
      model_mem[int'(addr) % mem_words] = data;
   endtask

   task automatic model_issue(input word_t ins, input int issue, input logic ph);
      reg_idx_t rs;
      reg_idx_t rt;
      reg_idx_t rd;
      word_t    imm;
      word_t    a;
      word_t    b;
      word_t    addr;
      rs   = ins[10:8];
      rt   = ins[7:5];
      rd   = ins[4:2];
      imm  = {{11{ins[4]}}, ins[4:0]};
      a    = model_regs[rs];
      b    = model_regs[rt];
      addr = a + imm;
      case (ins[15:11])
         OP_ADDI: expect_write(rt, addr, issue, ph);
         OP_RTYPE: begin
            case (ins[1:0])
               2'b00: expect_write(rd, a + b, issue, ph);
               2'b01: expect_write(rd, a - b, issue, ph);
               2'b10: expect_write(rd, a ^ b, issue, ph);
               default: expect_write(rd, a & ~b, issue, ph);
            endcase
         end
         OP_ST: expect_store(addr, b, issue, ph);
         OP_LD: expect_write(rt, model_mem[int'(addr) % mem_words], issue, ph);
         OP_STU: begin
            // Store data is read before the base is updated
            expect_store(addr, b, issue, ph);
            expect_write(rs, addr, issue, ph);
         end
         default: begin
            // Bubble, nothing retires
         end
      endcase
   endtask

   //////////////////////////////////////////////////////////////////////
   // Per-cycle strobe check, mid-cycle where outputs are stable
   //////////////////////////////////////////////////////////////////////

   task automatic check_cycle();
      int       now;
      logic     wb_due;
      logic     st_due;
      wb_item_t w;
      st_item_t s;
      now    = edge_cnt + 1;
      wb_due = wb_q.size() > 0 && wb_q[0].due == now;
      st_due = st_q.size() > 0 && st_q[0].due == now;
      if (wb_due && wb_en !== 1'b1) begin
         $display("Expected a write-back before edge %0d but wb_en stayed low", now);
         stop_on_error();
      end else if (!wb_due && wb_en !== 1'b0) begin
         $display("Unexpected write-back before edge %0d, wb_en is %b", now, wb_en);
         stop_on_error();
      end else if (wb_due) begin
         w = wb_q.pop_front();
         check_value("wb_rd", w.ph, {13'b0, w.rd}, {13'b0, wb_rd});
         check_value("wb_data", w.ph, w.data, wb_data);
      end
      if (st_due && mem_wr_en !== 1'b1) begin
         $display("Expected a store before edge %0d but mem_wr_en stayed low", now);
         stop_on_error();
      end else if (!st_due && mem_wr_en !== 1'b0) begin
         $display("Unexpected store before edge %0d, mem_wr_en is %b", now, mem_wr_en);
         stop_on_error();
      end else if (st_due) begin
         s = st_q.pop_front();
         check_value("mem_wr_addr", s.ph, s.addr, mem_wr_addr);
         check_value("mem_wr_data", s.ph, s.data, mem_wr_data);
      end
   endtask

   always @(negedge clk) begin
      if (checking) check_cycle();
   end

   initial begin : watchdog
      #(watchdog_ns);
      $display("Timeout: the instruction stream did not finish in time");
      stop_on_error();
   end

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin : main
      reset       = 1'b1;
      instr_valid = 1'b0;
      instr       = '0;
      seed        = 32'h77eb_6bd5;
      for (int i = 0; i < 8; i++) model_regs[i] = '0;
      for (int i = 0; i < mem_words; i++) model_mem[i] = '0;
      build_stream();
      // Strobes must stay low from the first reset edge on
      @(posedge clk);
      checking = 1'b1;
      repeat (reset_cycles - 1) @(posedge clk);
      #1;
      reset = 1'b0;
      for (int i = 0; i < n_instr; i++) begin
         instr_valid = stim_valid[i];
         instr       = stim_instr[i];
         if (stim_valid[i]) model_issue(stim_instr[i], edge_cnt + 1, i >= n_reset_loads);
         @(posedge clk);
         #1;
      end
      instr_valid = 1'b0;
      instr       = '0;
      // Drain, the write-back latency is three clocks
      repeat (6) @(posedge clk);
      if (wb_q.size() != 0 || st_q.size() != 0) begin
         $display("%0d write-backs and %0d stores never appeared", wb_q.size(), st_q.size());
         stop_on_error();
      end else begin
         $display("Done: no errors");
         $finish;
      end
   end

endmodule

/* verilog.f */
design/core_pkg.sv
design/pipe_if.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/result_stage.sv
design/pipe_core.sv
sim/tb_pipe_core.sv

/* Makefile */
# Verilator build and run for the pipeline testbench
# Override any variable on the command line, e.g. make run JOBS=8

VERILATOR ?= verilator
TOP       ?= tb_pipe_core
FLIST     ?= verilog.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE) -j $(JOBS)

SOURCES := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# The simulator exits non-zero on $fatal, so make fails with it
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
